// ==== hw/video_settings.svh ====
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Width of pixel and line counters
`define COORD_W 11

// Switch codes for the mode selector
`define SW_VGA    4'b0000
`define SW_SVGA   4'b0001
`define SW_XGA    4'b0011
`define SW_HD720  4'b0010
`define SW_SXGA   4'b1000
`define SW_CAMERA 4'b1001

// Cycles a new code must stay put before it counts
`define DEBOUNCE_CYCLES 16

////////////////////////////////////////////////////////////////////////////
// Per-mode sizes in pixels (horizontal) and lines (vertical)
////////////////////////////////////////////////////////////////////////////

// 640x480 at 60 Hz
`define HPIXELS_VGA 640
`define VLINES_VGA  480
`define HSYNCPW_VGA 96
`define VSYNCPW_VGA 2
`define HFNPRCH_VGA 16
`define VFNPRCH_VGA 11
`define HBKPRCH_VGA 48
`define VBKPRCH_VGA 31

// 800x600 at 60 Hz
`define HPIXELS_SVGA 800
`define VLINES_SVGA  600
`define HSYNCPW_SVGA 128
`define VSYNCPW_SVGA 4
`define HFNPRCH_SVGA 40
`define VFNPRCH_SVGA 1
`define HBKPRCH_SVGA 88
`define VBKPRCH_SVGA 23

// 1024x768 at 60 Hz
`define HPIXELS_XGA 1024
`define VLINES_XGA  768
`define HSYNCPW_XGA 136
`define VSYNCPW_XGA 6
`define HFNPRCH_XGA 24
`define VFNPRCH_XGA 3
`define HBKPRCH_XGA 160
`define VBKPRCH_XGA 29

// 1280x720 at 60 Hz and fallback for unknown codes
`define HPIXELS_HD720 1280
`define VLINES_HD720  720
`define HSYNCPW_HD720 40
`define VSYNCPW_HD720 5
`define HFNPRCH_HD720 110
`define VFNPRCH_HD720 5
`define HBKPRCH_HD720 220
`define VBKPRCH_HD720 20

// 1280x1024 at 60 Hz
`define HPIXELS_SXGA 1280
`define VLINES_SXGA  1024
`define HSYNCPW_SXGA 112
`define VSYNCPW_SXGA 3
`define HFNPRCH_SXGA 48
`define VFNPRCH_SXGA 1
`define HBKPRCH_SXGA 248
`define VBKPRCH_SXGA 38

// Camera 720p with trimmed sync and porches
`define HPIXELS_CAMERA 1280
`define VLINES_CAMERA  720
`define HSYNCPW_CAMERA 39
`define VSYNCPW_CAMERA 4
`define HFNPRCH_CAMERA 110
`define VFNPRCH_CAMERA 4
`define HBKPRCH_CAMERA 220
`define VBKPRCH_CAMERA 22

`endif

// ==== hw/video_pkg.sv ====
`include "video_settings.svh"

package video_pkg;

	// Pixel or line position or a threshold
	typedef logic [`COORD_W-1:0] coord_t;

	typedef logic [3:0] sw_code_t; // Raw code from the four switches

	// Supported display modes
	typedef enum logic [2:0] {
		MODE_VGA,
		MODE_SVGA,
		MODE_XGA,
		MODE_HD720, // Also taken for unlisted codes
		MODE_SXGA,
		MODE_CAMERA
	} video_mode_e;

	////////////////////////////////////////////////////////////////////////////
	// Timing records
	////////////////////////////////////////////////////////////////////////////

	// Axis thresholds as the last count of each interval
	typedef struct packed {
		coord_t sblnk; // Last active
		coord_t ssync; // Last before sync
		coord_t esync; // Last sync
		coord_t eblnk; // Last of line or frame
	} axis_timing_t;

	// Full mode record
	typedef struct packed {
		axis_timing_t h;        // Pixels
		axis_timing_t v;        // Lines
		logic         sync_neg; // Active-low sync
	} video_timing_t;

	// Counter flags before polarity and delay
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblnk;
		logic vblnk;
	} raw_sync_t;

endpackage

// ==== hw/mode_select.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module mode_select (
	input  logic                     clk50m_bufg,
	input  logic                     rst_n,
	input  video_pkg::sw_code_t      sw,
	output video_pkg::video_timing_t timing,
	output logic                     sync_neg,
	output logic                     restart
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);

	video_pkg::sw_code_t      sw_meta;    // First sync flop
	video_pkg::sw_code_t      sw_sync;    // Second sync flop
	video_pkg::sw_code_t      sw_last;    // Code under observation
	logic [CNT_W-1:0]         stable_cnt; // Cycles sw_last has held
	video_pkg::video_mode_e   cur_mode;
	video_pkg::video_mode_e   cand_mode;
	video_pkg::video_timing_t cand_timing;
	logic                     accept;

	// Unknown switch codes fall back to 720p
	function automatic video_pkg::video_mode_e code_to_mode(input video_pkg::sw_code_t code);
		case (code)
			`SW_VGA:    code_to_mode = video_pkg::MODE_VGA;
			`SW_SVGA:   code_to_mode = video_pkg::MODE_SVGA;
			`SW_XGA:    code_to_mode = video_pkg::MODE_XGA;
			`SW_HD720:  code_to_mode = video_pkg::MODE_HD720;
			`SW_SXGA:   code_to_mode = video_pkg::MODE_SXGA;
			`SW_CAMERA: code_to_mode = video_pkg::MODE_CAMERA;
			default:    code_to_mode = video_pkg::MODE_HD720;
		endcase
	endfunction

	// Running sums of active, front porch, sync and back porch
	function automatic video_pkg::axis_timing_t axis_calc(
		input int act,
		input int fp,
		input int pw,
		input int bp
	);
		video_pkg::axis_timing_t a;
		a.sblnk = video_pkg::coord_t'(act - 1);
		a.ssync = video_pkg::coord_t'(act - 1 + fp);
		a.esync = video_pkg::coord_t'(act - 1 + fp + pw);
		a.eblnk = video_pkg::coord_t'(act - 1 + fp + pw + bp); // Total minus one
		return a;
	endfunction

	function automatic video_pkg::video_timing_t mode_timing(input video_pkg::video_mode_e mode);
		video_pkg::video_timing_t t;
		case (mode)
			video_pkg::MODE_VGA: begin
				t.h = axis_calc(`HPIXELS_VGA, `HFNPRCH_VGA,
					`HSYNCPW_VGA, `HBKPRCH_VGA);
				t.v = axis_calc(`VLINES_VGA, `VFNPRCH_VGA,
					`VSYNCPW_VGA, `VBKPRCH_VGA);
				t.sync_neg = 1'b1;
			end
			video_pkg::MODE_SVGA: begin
				t.h = axis_calc(`HPIXELS_SVGA, `HFNPRCH_SVGA,
					`HSYNCPW_SVGA, `HBKPRCH_SVGA);
				t.v = axis_calc(`VLINES_SVGA, `VFNPRCH_SVGA,
					`VSYNCPW_SVGA, `VBKPRCH_SVGA);
				t.sync_neg = 1'b0; // Positive sync
			end
			video_pkg::MODE_XGA: begin
				t.h = axis_calc(`HPIXELS_XGA, `HFNPRCH_XGA,
					`HSYNCPW_XGA, `HBKPRCH_XGA);
				t.v = axis_calc(`VLINES_XGA, `VFNPRCH_XGA,
					`VSYNCPW_XGA, `VBKPRCH_XGA);
				t.sync_neg = 1'b1;
			end
			video_pkg::MODE_SXGA: begin
				t.h = axis_calc(`HPIXELS_SXGA, `HFNPRCH_SXGA,
					`HSYNCPW_SXGA, `HBKPRCH_SXGA);
				t.v = axis_calc(`VLINES_SXGA, `VFNPRCH_SXGA,
					`VSYNCPW_SXGA, `VBKPRCH_SXGA);
				t.sync_neg = 1'b0;
			end
			video_pkg::MODE_CAMERA: begin
				t.h = axis_calc(`HPIXELS_CAMERA, `HFNPRCH_CAMERA,
					`HSYNCPW_CAMERA, `HBKPRCH_CAMERA);
				t.v = axis_calc(`VLINES_CAMERA, `VFNPRCH_CAMERA,
					`VSYNCPW_CAMERA, `VBKPRCH_CAMERA);
				t.sync_neg = 1'b0;
			end
			default: begin // 720p
				t.h = axis_calc(`HPIXELS_HD720, `HFNPRCH_HD720,
					`HSYNCPW_HD720, `HBKPRCH_HD720);
				t.v = axis_calc(`VLINES_HD720, `VFNPRCH_HD720,
					`VSYNCPW_HD720, `VBKPRCH_HD720);
				t.sync_neg = 1'b0;
			end
		endcase
		return t;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Switch synchronizer and debounce
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			sw_meta <= `SW_VGA;
			sw_sync <= `SW_VGA;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	// Any change restarts the hold count
	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			sw_last    <= `SW_VGA;
			stable_cnt <= '0;
		end else if (sw_sync != sw_last) begin
			sw_last    <= sw_sync;
			stable_cnt <= '0;
		end else if (stable_cnt != CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
			stable_cnt <= stable_cnt + 1'b1; // Saturates at the limit
		end
	end

	assign cand_mode   = code_to_mode(sw_last);
	assign cand_timing = mode_timing(cand_mode);

	// Held long enough and actually a different mode
	assign accept = (sw_sync == sw_last) &&
		(stable_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) &&
		(cand_mode != cur_mode);

	////////////////////////////////////////////////////////////////////////////
	// Registered mode record
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			cur_mode <= video_pkg::MODE_VGA;
			timing   <= mode_timing(video_pkg::MODE_VGA);
			sync_neg <= 1'b1; // VGA sync is active low
			restart  <= 1'b0;
		end else begin
			restart <= accept; // One-cycle pulse with the new record
			if (accept) begin
				cur_mode <= cand_mode;
				timing   <= cand_timing;
				sync_neg <= cand_timing.sync_neg;
			end
		end
	end

endmodule

// ==== hw/video_timing_gen.sv ====
`timescale 1ns/1ps

module video_timing_gen (
	input  logic                     clk50m_bufg,
	input  logic                     rst_n,
	input  video_pkg::video_timing_t timing,
	input  logic                     restart,
	output video_pkg::raw_sync_t     raw
);

	video_pkg::coord_t hcount; // Pixel within line
	video_pkg::coord_t vcount; // Line within frame
	logic              line_end;
	logic              frame_end;

	// Last pixel of the line and last line of the frame
	assign line_end  = (hcount >= timing.h.eblnk);
	assign frame_end = (vcount >= timing.v.eblnk);

	////////////////////////////////////////////////////////////////////////////
	// Line and frame counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (restart) begin
			// New mode starts from the top left
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			if (frame_end)
				vcount <= '0;
			else
				vcount <= vcount + 1'b1; // Advance once per line
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Blank and sync flags
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Blank starts right after the last active pixel
		raw.hblnk = (hcount > timing.h.sblnk);
		raw.vblnk = (vcount > timing.v.sblnk);

		// Sync covers ssync+1 up to esync
		raw.hsync = (hcount > timing.h.ssync) && (hcount <= timing.h.esync);
		raw.vsync = (vcount > timing.v.ssync) && (vcount <= timing.v.esync);
	end

endmodule

// ==== hw/sync_de_out.sv ====
`timescale 1ns/1ps

module sync_de_out (
	input  logic                 clk50m_bufg,
	input  logic                 rst_n,
	input  video_pkg::raw_sync_t raw,
	input  logic                 sync_neg,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 de
);

	logic hsync_q; // Stage one
	logic vsync_q;
	logic de_q;
	logic active;

	// Visible only when both axes are outside blanking
	assign active = !raw.hblnk && !raw.vblnk;

	////////////////////////////////////////////////////////////////////////////
	// Two-stage output pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg or negedge rst_n) begin
		if (!rst_n) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			de_q    <= 1'b0;
			hsync   <= 1'b0;
			vsync   <= 1'b0;
			de      <= 1'b0;
		end else begin
			hsync_q <= raw.hsync ^ sync_neg; // Polarity flip
			vsync_q <= raw.vsync ^ sync_neg;
			de_q    <= active;
			// Second stage drives the pins
			hsync <= hsync_q;
			vsync <= vsync_q;
			de    <= de_q;
		end
	end

endmodule

// ==== hw/video_top.sv ====
`timescale 1ns/1ps

module video_top (
	input  logic                clk50m_bufg,
	input  logic                rst_n,
	input  video_pkg::sw_code_t sw,
	output logic                hsync,
	output logic                vsync,
	output logic                de
);

	video_pkg::video_timing_t timing;   // Thresholds of the current mode
	logic                     sync_neg;
	logic                     restart;  // Pulse on mode change
	video_pkg::raw_sync_t     raw;

	// Switches to mode record
	mode_select u_mode_select (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.sw          (sw),
		.timing      (timing),
		.sync_neg    (sync_neg),
		.restart     (restart)
	);

	// Counters and raw flags
	video_timing_gen u_video_timing_gen (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.timing      (timing),
		.restart     (restart),
		.raw         (raw)
	);

	// Polarity and output registers
	sync_de_out u_sync_de_out (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.raw         (raw),
		.sync_neg    (sync_neg),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

endmodule

// ==== test/tb_video_top.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module tb_video_top;

	// Expected figures for one mode, all in cycles or lines
	typedef struct packed {
		int   line_len;    // Cycles between hsync leading edges
		int   hs_width;    // Active hsync cycles
		int   de_width;    // de-high cycles per line
		int   frame_lines; // Lines between vsync leading edges
		int   de_lines;    // Lines with de per frame
		int   vs_width;    // vsync length in lines
		logic sync_neg;    // Active-low sync
	} expect_t;

	// Sync flops, hold count, restart and the 2-stage output, plus slack
	localparam int SETTLE_CYCLES = `DEBOUNCE_CYCLES + 12;
	localparam int GLITCHES      = 80;

	localparam int FRAME_VGA = (`HPIXELS_VGA + `HFNPRCH_VGA + `HSYNCPW_VGA + `HBKPRCH_VGA) *
		(`VLINES_VGA + `VFNPRCH_VGA + `VSYNCPW_VGA + `VBKPRCH_VGA);
	localparam int FRAME_SVGA = (`HPIXELS_SVGA + `HFNPRCH_SVGA + `HSYNCPW_SVGA + `HBKPRCH_SVGA) *
		(`VLINES_SVGA + `VFNPRCH_SVGA + `VSYNCPW_SVGA + `VBKPRCH_SVGA);
	localparam int FRAME_HD720 =
		(`HPIXELS_HD720 + `HFNPRCH_HD720 + `HSYNCPW_HD720 + `HBKPRCH_HD720) *
		(`VLINES_HD720 + `VFNPRCH_HD720 + `VSYNCPW_HD720 + `VBKPRCH_HD720);
	// Each mode needs at most about two frames, three leaves room for glitches
	localparam int TIMEOUT_CYCLES = 3 * (FRAME_VGA + FRAME_SVGA + FRAME_HD720) + 100000;

	logic                clk50m_bufg;
	logic                rst_n;
	video_pkg::sw_code_t sw;
	logic                hsync;
	logic                vsync;
	logic                de;

	expect_t     exp_cfg;          // Current mode under check
	logic        armed;            // Monitors running
	logic [31:0] lcg_state = 32'd47;
	int          cycle_count  = 0;
	int          line_checks  = 0;
	int          frame_checks = 0;
	int          vs_checks    = 0;

	// Monitor state
	logic hs_now;      // hsync at its active level
	logic vs_now;
	logic hs_prev;
	logic vs_prev;
	logic de_prev;
	logic hs_seen;     // Leading edge found since arming
	logic de_seen;
	logic vs_seen;
	int   period_cnt;  // Cycles since the last hsync edge
	int   pw_cnt;
	int   de_run;
	int   de_lines;
	int   frame_lines; // hsync edges since the last vsync edge
	int   vs_lines;

	video_top uut (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input int got, input int want);
		$display("ERROR %s got 0x%0h expected 0x%0h", name, got, want);
		abort_run();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR %s", what);
		abort_run();
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Figures follow from the interval sizes alone
	function automatic expect_t make_expect(input int hpix, input int hfp, input int hpw,
		input int hbp, input int vlin, input int vfp, input int vpw, input int vbp,
		input logic neg);
		expect_t e;
		e.line_len    = hpix + hfp + hpw + hbp;
		e.hs_width    = hpw;
		e.de_width    = hpix;
		e.frame_lines = vlin + vfp + vpw + vbp;
		e.de_lines    = vlin;
		e.vs_width    = vpw;
		e.sync_neg    = neg;
		return e;
	endfunction

	// Monitors stop, new code goes out, checks restart once the mode has taken
	task automatic change_mode(input video_pkg::sw_code_t code, input expect_t cfg);
		armed   = 1'b0;
		sw      = code;
		exp_cfg = cfg;
		repeat (SETTLE_CYCLES) @(negedge clk50m_bufg);
		armed = 1'b1;
	endtask

	task automatic wait_frame_checks();
		int f0;
		int v0;
		f0 = frame_checks;
		v0 = vs_checks;
		// Until a full frame and a vsync pulse have been measured
		while (frame_checks <= f0 || vs_checks <= v0)
			@(negedge clk50m_bufg);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Line and frame monitors
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk50m_bufg) begin
		hs_now = exp_cfg.sync_neg ? !hsync : hsync; // Active level
		vs_now = exp_cfg.sync_neg ? !vsync : vsync;
		if (!rst_n || !armed) begin
			hs_seen = 1'b0;
			de_seen = 1'b0;
			vs_seen = 1'b0;
			period_cnt = 0;
			pw_cnt = 0;
			de_run = 0;
			de_lines = 0;
			frame_lines = 0;
			vs_lines = 0;
		end else begin
			period_cnt++;
			if (hs_now && !hs_prev) begin
				if (hs_seen) begin // First edge only starts the count
					assert (period_cnt == exp_cfg.line_len)
						else report_mismatch("hsync_period", period_cnt, exp_cfg.line_len);
					line_checks++;
				end
				hs_seen = 1'b1;
				period_cnt = 0;
				pw_cnt = 0;
				frame_lines++;
				if (vs_now)
					vs_lines++; // One hsync per vsync line
			end
			if (hs_now)
				pw_cnt++;
			if (!hs_now && hs_prev && hs_seen)
				assert (pw_cnt == exp_cfg.hs_width)
					else report_mismatch("hsync_width", pw_cnt, exp_cfg.hs_width);

			if (de && !de_prev) begin
				de_seen = 1'b1;
				de_run = 0;
				de_lines++;
			end
			if (de)
				de_run++;
			if (!de && de_prev && de_seen)
				assert (de_run == exp_cfg.de_width)
					else report_mismatch("de_width", de_run, exp_cfg.de_width);

			// Frame figures close on each vsync leading edge
			if (vs_now && !vs_prev) begin
				if (vs_seen) begin
					assert (de_lines == exp_cfg.de_lines)
						else report_mismatch("de_lines", de_lines, exp_cfg.de_lines);
					assert (frame_lines == exp_cfg.frame_lines)
						else report_mismatch("frame_lines", frame_lines, exp_cfg.frame_lines);
					frame_checks++;
				end
				vs_seen = 1'b1;
				de_lines = 0;
				frame_lines = 0;
				vs_lines = 0;
			end
			if (!vs_now && vs_prev && vs_seen) begin
				assert (vs_lines == exp_cfg.vs_width)
					else report_mismatch("vsync_width", vs_lines, exp_cfg.vs_width);
				vs_checks++;
			end
		end
		hs_prev = hs_now;
		vs_prev = vs_now;
		de_prev = de;
	end

	always @(posedge clk50m_bufg) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_problem("timeout, the checks did not complete in time");
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int i;
		int glitch_len;
		int gap_len;
		int base;
		rst_n = 1'b0;
		sw    = `SW_VGA;
		armed = 1'b0;
		exp_cfg = make_expect(`HPIXELS_VGA, `HFNPRCH_VGA, `HSYNCPW_VGA, `HBKPRCH_VGA,
			`VLINES_VGA, `VFNPRCH_VGA, `VSYNCPW_VGA, `VBKPRCH_VGA, 1'b1);

		// de must stay low during reset
		repeat (5) begin
			@(negedge clk50m_bufg);
			assert (de == 1'b0) else report_mismatch("de", int'(de), 0);
		end
		rst_n = 1'b1;

		// Pixel 0 is active, so de shows up after the 2-cycle output lag
		@(negedge clk50m_bufg);
		assert (de == 1'b0) else report_mismatch("de", int'(de), 0);
		@(negedge clk50m_bufg);
		assert (de == 1'b1) else report_mismatch("de", int'(de), 1);
		assert (hsync == 1'b1) else report_mismatch("hsync", int'(hsync), 1); // Idle high

		// VGA straight out of reset
		armed = 1'b1;
		wait_frame_checks();

		// Short glitches must not change the mode
		base = line_checks;
		for (i = 0; i < GLITCHES; i++) begin
			lcg_state  = lcg_next(lcg_state);
			glitch_len = 1 + int'((lcg_state >> 16) % (`DEBOUNCE_CYCLES - 1));
			sw         = lcg_state[27:24];
			repeat (glitch_len) @(negedge clk50m_bufg);
			lcg_state = lcg_next(lcg_state);
			gap_len   = 1 + int'((lcg_state >> 16) % 24);
			sw        = `SW_VGA;
			repeat (gap_len) @(negedge clk50m_bufg);
		end
		wait (line_checks >= base + 4);
		@(negedge clk50m_bufg);

		// SVGA with positive sync
		change_mode(`SW_SVGA, make_expect(`HPIXELS_SVGA, `HFNPRCH_SVGA, `HSYNCPW_SVGA,
			`HBKPRCH_SVGA, `VLINES_SVGA, `VFNPRCH_SVGA, `VSYNCPW_SVGA, `VBKPRCH_SVGA, 1'b0));
		wait_frame_checks();

		// Unlisted code falls back to 720p
		change_mode(4'b0111, make_expect(`HPIXELS_HD720, `HFNPRCH_HD720, `HSYNCPW_HD720,
			`HBKPRCH_HD720, `VLINES_HD720, `VFNPRCH_HD720, `VSYNCPW_HD720, `VBKPRCH_HD720,
			1'b0));
		wait_frame_checks();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== video_timing.f ====
+incdir+hw
hw/video_pkg.sv
hw/mode_select.sv
hw/video_timing_gen.sv
hw/sync_de_out.sv
hw/video_top.sv
test/tb_video_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f video_timing.f --top-module tb_video_top -o sim_video_top &&
{ ./obj_dir/sim_video_top > sim.log 2>&1; cat sim.log; } &&
grep -qx "TESTS PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
